/* logic/kinpira_pkg.sv */
package kinpira_pkg;

  // Data path widths
  localparam int DWIDTH   = 16;
  localparam int BWIDTH   = 32;
  localparam int LWIDTH   = 16;
  localparam int ACCWIDTH = 40;

  // Fixed point format; the accumulated result is shifted right arithmetically
  localparam int FRACBITS = 8;

  // Address widths of the memories and of the register window
  localparam int IMGSIZE  = 10;
  localparam int NETSIZE  = 11;
  localparam int REGSIZE  = 5;

  // ==============================
  // Register word indices
  // ==============================
  localparam logic [REGSIZE-1:0] REG_REQ        = 5'd1;
  localparam logic [REGSIZE-1:0] REG_IN_OFFSET  = 5'd2;
  localparam logic [REGSIZE-1:0] REG_OUT_OFFSET = 5'd3;
  localparam logic [REGSIZE-1:0] REG_NET_OFFSET = 5'd4;
  localparam logic [REGSIZE-1:0] REG_BASE_PARAM = 5'd9;
  localparam logic [REGSIZE-1:0] REG_STATUS     = 5'd30;

  // ==============================
  // Dense engine FSM states
  // ==============================
  localparam logic [1:0] GB_IDLE  = 2'd0;
  localparam logic [1:0] GB_ISSUE = 2'd1;
  localparam logic [1:0] GB_DRAIN = 2'd2;
  localparam logic [1:0] GB_WRITE = 2'd3;

endpackage

/* logic/ninjin_regs.sv */
`timescale 1ns/1ps

module ninjin_regs import kinpira_pkg::*; (
  input  logic               clk,
  input  logic               xrst,
  input  logic               reg_we,
  input  logic [REGSIZE-1:0] reg_addr,
  input  logic [BWIDTH-1:0]  reg_wdata,
  input  logic               busy,
  output logic [BWIDTH-1:0]  reg_rdata,
  output logic               start,
  output logic [IMGSIZE-1:0] in_offset,
  output logic [IMGSIZE-1:0] out_offset,
  output logic [NETSIZE-1:0] net_offset,
  output logic [LWIDTH-1:0]  total_in,
  output logic [LWIDTH-1:0]  total_out
);

  logic [BWIDTH-1:0] req_word;
  logic [BWIDTH-1:0] in_word;
  logic [BWIDTH-1:0] out_word;
  logic [BWIDTH-1:0] net_word;
  logic [BWIDTH-1:0] base_word;
  logic              req_prev;

  // Layer parameters as levels
  assign in_offset  = in_word[IMGSIZE-1:0];
  assign out_offset = out_word[IMGSIZE-1:0];
  assign net_offset = net_word[NETSIZE-1:0];
  assign total_out  = base_word[2*LWIDTH-1:LWIDTH];
  assign total_in   = base_word[LWIDTH-1:0];

  // ==============================
  // Register storage
  // ==============================
  always_ff @(posedge clk) begin
    if (!xrst) begin
      req_word  <= '0;
      in_word   <= '0;
      out_word  <= '0;
      net_word  <= '0;
      base_word <= '0;
    end else if (reg_we) begin
      case (reg_addr)
        REG_REQ:        req_word  <= reg_wdata;
        REG_IN_OFFSET:  in_word   <= reg_wdata;
        REG_OUT_OFFSET: out_word  <= reg_wdata;
        REG_NET_OFFSET: net_word  <= reg_wdata;
        REG_BASE_PARAM: base_word <= reg_wdata;
        default: ;
      endcase
    end
  end

  // Rising edge of req bit, one cycle late
  always_ff @(posedge clk) begin
    if (!xrst) begin
      req_prev <= 1'b0;
      start    <= 1'b0;
    end else begin
      req_prev <= req_word[0];
      start    <= req_word[0] && !req_prev;
    end
  end

  // ==============================
  // Read mux
  // ==============================
  always_comb begin
    case (reg_addr)
      REG_REQ:        reg_rdata = req_word;
      REG_IN_OFFSET:  reg_rdata = in_word;
      REG_OUT_OFFSET: reg_rdata = out_word;
      REG_NET_OFFSET: reg_rdata = net_word;
      REG_BASE_PARAM: reg_rdata = base_word;
      // ack is the inverse of busy
      REG_STATUS:     reg_rdata = {{(BWIDTH-1){1'b0}}, !busy};
      default:        reg_rdata = '0;
    endcase
  end

  // Host must not restart a layer that is still running
  assert property (@(posedge clk) disable iff (!xrst) start |-> !busy)
    else $error("ninjin_regs: start while engine busy");

endmodule

/* logic/ninjin_img_buf.sv */
`timescale 1ns/1ps

module ninjin_img_buf import kinpira_pkg::*; (
  input  logic                     clk,
  input  logic                     busy,
  input  logic                     host_we,
  input  logic [IMGSIZE-1:0]       host_addr,
  input  logic signed [DWIDTH-1:0] host_wdata,
  input  logic                     core_we,
  input  logic [IMGSIZE-1:0]       core_addr,
  input  logic signed [DWIDTH-1:0] core_wdata,
  output logic signed [DWIDTH-1:0] rdata
);

  logic signed [DWIDTH-1:0] mem [0:(1<<IMGSIZE)-1];

  logic                     we;
  logic [IMGSIZE-1:0]       addr;
  logic signed [DWIDTH-1:0] wdata;

  // Engine owns the port for the whole layer
  assign we    = busy ? core_we    : host_we;
  assign addr  = busy ? core_addr  : host_addr;
  assign wdata = busy ? core_wdata : host_wdata;

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];
  end

  // Engine writes only inside its own busy window
  assert property (@(posedge clk) core_we |-> busy)
    else $error("ninjin_img_buf: core write outside busy");

endmodule

/* logic/gobou_dense.sv */
`timescale 1ns/1ps

module gobou_dense import kinpira_pkg::*; (
  input  logic                     clk,
  input  logic                     xrst,
  input  logic                     start,
  input  logic [IMGSIZE-1:0]       in_offset,
  input  logic [IMGSIZE-1:0]       out_offset,
  input  logic [NETSIZE-1:0]       net_offset,
  input  logic [LWIDTH-1:0]        total_in,
  input  logic [LWIDTH-1:0]        total_out,
  input  logic                     net_we,
  input  logic [NETSIZE-1:0]       net_addr,
  input  logic signed [DWIDTH-1:0] net_wdata,
  input  logic signed [DWIDTH-1:0] img_rdata,
  output logic                     busy,
  output logic                     core_we,
  output logic [IMGSIZE-1:0]       core_addr,
  output logic signed [DWIDTH-1:0] core_wdata
);

  logic signed [DWIDTH-1:0]   net_mem [0:(1<<NETSIZE)-1];
  logic signed [DWIDTH-1:0]   w_rdata;
  logic [NETSIZE-1:0]         w_addr;

  logic [1:0]                 state;
  logic [LWIDTH-1:0]          in_cnt;
  logic [LWIDTH-1:0]          out_cnt;
  logic                       issue;
  logic                       last_in;

  // Read pipeline flags
  logic                       v1;
  logic                       b1;
  logic                       v2;

  logic signed [2*DWIDTH-1:0] prod;
  logic signed [ACCWIDTH-1:0] term;
  logic signed [ACCWIDTH-1:0] acc;
  logic signed [ACCWIDTH:0]   acc_sum;
  logic signed [ACCWIDTH-1:0] acc_shift;

  assign busy    = state != GB_IDLE;
  assign issue   = state == GB_ISSUE;
  assign core_we = state == GB_WRITE;
  assign last_in = in_cnt == total_in;

  // ==============================
  // Weight memory
  // ==============================
  always_ff @(posedge clk) begin
    if (net_we && !busy) begin
      net_mem[net_addr] <= net_wdata;
    end
    w_rdata <= net_mem[w_addr];
  end

  // Write slot borrows the single image port
  assign core_addr = core_we ? out_offset + out_cnt[IMGSIZE-1:0]
                             : in_offset + in_cnt[IMGSIZE-1:0];

  // ==============================
  // Sequencer
  // ==============================
  // Per output: total_in weights then the bias word, so the
  // weight address simply runs on from net_offset
  always_ff @(posedge clk) begin
    if (!xrst) begin
      state   <= GB_IDLE;
      in_cnt  <= '0;
      out_cnt <= '0;
      w_addr  <= '0;
    end else begin
      case (state)
        GB_IDLE: begin
          in_cnt  <= '0;
          out_cnt <= '0;
          w_addr  <= net_offset;
          // Empty layer has nothing to do
          if (start && total_out != '0) begin
            state <= GB_ISSUE;
          end
        end
        GB_ISSUE: begin
          w_addr <= w_addr + 1'b1;
          if (last_in) begin
            in_cnt <= '0;
            state  <= GB_DRAIN;
          end else begin
            in_cnt <= in_cnt + 1'b1;
          end
        end
        GB_DRAIN: begin
          // Final term lands in acc at this edge
          if (!v1 && v2) begin
            state <= GB_WRITE;
          end
        end
        GB_WRITE: begin
          out_cnt <= out_cnt + 1'b1;
          if (out_cnt == total_out - 1'b1) begin
            state <= GB_IDLE;
          end else begin
            state <= GB_ISSUE;
          end
        end
        default: begin
          state <= GB_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      v1 <= 1'b0;
      b1 <= 1'b0;
      v2 <= 1'b0;
    end else begin
      v1 <= issue;
      b1 <= issue && last_in;
      v2 <= v1;
    end
  end

  // ==============================
  // Multiply accumulate
  // ==============================
  assign prod = img_rdata * w_rdata;

  // Bias enters pre-scaled to the product format
  always_ff @(posedge clk) begin
    if (b1) begin
      term <= {{(ACCWIDTH-DWIDTH-FRACBITS){w_rdata[DWIDTH-1]}}, w_rdata,
               {FRACBITS{1'b0}}};
    end else begin
      term <= {{(ACCWIDTH-2*DWIDTH){prod[2*DWIDTH-1]}}, prod};
    end
  end

  assign acc_sum = {acc[ACCWIDTH-1], acc} + {term[ACCWIDTH-1], term};

  always_ff @(posedge clk) begin
    if (state == GB_IDLE || state == GB_WRITE) begin
      acc <= '0;
    end else if (v2) begin
      acc <= acc_sum[ACCWIDTH-1:0];
    end
  end

  // ReLU, then clamp to the largest positive word
  assign acc_shift = acc >>> FRACBITS;

  always_comb begin
    if (acc_shift[ACCWIDTH-1]) begin
      core_wdata = '0;
    end else if (|acc_shift[ACCWIDTH-2:DWIDTH-1]) begin
      core_wdata = {1'b0, {(DWIDTH-1){1'b1}}};
    end else begin
      core_wdata = acc_shift[DWIDTH-1:0];
    end
  end

  // Sum over a whole output must stay inside the accumulator
  assert property (@(posedge clk) disable iff (!xrst)
    v2 |-> acc_sum[ACCWIDTH] == acc_sum[ACCWIDTH-1])
    else $error("gobou_dense: accumulator overflow");

endmodule

/* logic/kinpira_core.sv */
`timescale 1ns/1ps

module kinpira_core import kinpira_pkg::*; (
  input  logic                     clk,
  input  logic                     xrst,
  // Register window
  input  logic                     reg_we,
  input  logic [REGSIZE-1:0]       reg_addr,
  input  logic [BWIDTH-1:0]        reg_wdata,
  output logic [BWIDTH-1:0]        reg_rdata,
  // Weight load, write only
  input  logic                     net_we,
  input  logic [NETSIZE-1:0]       net_addr,
  input  logic signed [DWIDTH-1:0] net_wdata,
  // Activation buffer, host side
  input  logic                     img_we,
  input  logic [IMGSIZE-1:0]       img_addr,
  input  logic signed [DWIDTH-1:0] img_wdata,
  output logic signed [DWIDTH-1:0] img_rdata
);

  // ==============================
  // Control between regs and engine
  // ==============================
  logic                     start;
  logic                     busy;
  logic [IMGSIZE-1:0]       in_offset;
  logic [IMGSIZE-1:0]       out_offset;
  logic [NETSIZE-1:0]       net_offset;
  logic [LWIDTH-1:0]        total_in;
  logic [LWIDTH-1:0]        total_out;

  // Engine side of the image buffer
  logic                     core_we;
  logic [IMGSIZE-1:0]       core_addr;
  logic signed [DWIDTH-1:0] core_wdata;

  ninjin_regs regs0 (
    .clk        (clk),
    .xrst       (xrst),
    .reg_we     (reg_we),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .busy       (busy),
    .reg_rdata  (reg_rdata),
    .start      (start),
    .in_offset  (in_offset),
    .out_offset (out_offset),
    .net_offset (net_offset),
    .total_in   (total_in),
    .total_out  (total_out)
  );

  ninjin_img_buf mem_img (
    .clk        (clk),
    .busy       (busy),
    .host_we    (img_we),
    .host_addr  (img_addr),
    .host_wdata (img_wdata),
    .core_we    (core_we),
    .core_addr  (core_addr),
    .core_wdata (core_wdata),
    .rdata      (img_rdata)
  );

  gobou_dense gobou0 (
    .clk        (clk),
    .xrst       (xrst),
    .start      (start),
    .in_offset  (in_offset),
    .out_offset (out_offset),
    .net_offset (net_offset),
    .total_in   (total_in),
    .total_out  (total_out),
    .net_we     (net_we),
    .net_addr   (net_addr),
    .net_wdata  (net_wdata),
    .img_rdata  (img_rdata),
    .busy       (busy),
    .core_we    (core_we),
    .core_addr  (core_addr),
    .core_wdata (core_wdata)
  );

endmodule

/* bench/kinpira_core_tb.sv */
`timescale 1ns/1ps

module kinpira_core_tb import kinpira_pkg::*; ();

  localparam int CLK_PERIOD = 20;
  localparam int DRV        = 2;
  localparam int SEED       = 72420;
  localparam int MAXVAL     = (1 << (DWIDTH-1)) - 1;
  localparam int SCRATCH    = 1000;

  // ==============================
  // Layer table
  // ==============================
  // Columns are total_in, total_out, in_offset, out_offset, net_offset,
  // data mode (0 mixed signs, 1 sign set by output parity) and amplitude
  localparam int NCASES = 6;
  localparam int C_TIN  = 0;
  localparam int C_TOUT = 1;
  localparam int C_IN   = 2;
  localparam int C_OUT  = 3;
  localparam int C_NET  = 4;
  localparam int C_MODE = 5;
  localparam int C_AMP  = 6;

  int case_tab [NCASES][7] = '{
    '{ 8, 4,   0, 100,    0, 0,  300},
    '{16, 8, 200, 300,  100, 1, 4000},
    '{ 1, 3, 400, 420,  300, 0, 1000},
    '{32, 6, 500, 600,  400, 0,  300},
    '{12, 5, 700, 800, 1900, 1, 2000},
    '{ 0, 2, 900, 910, 1000, 0, 2000}
  };

  logic                     clk;
  logic                     xrst;
  logic                     reg_we;
  logic [REGSIZE-1:0]       reg_addr;
  logic [BWIDTH-1:0]        reg_wdata;
  logic [BWIDTH-1:0]        reg_rdata;
  logic                     net_we;
  logic [NETSIZE-1:0]       net_addr;
  logic signed [DWIDTH-1:0] net_wdata;
  logic                     img_we;
  logic [IMGSIZE-1:0]       img_addr;
  logic signed [DWIDTH-1:0] img_wdata;
  logic signed [DWIDTH-1:0] img_rdata;

  // Shadow copies of both memories
  int img_model [0:(1<<IMGSIZE)-1];
  bit img_known [0:(1<<IMGSIZE)-1];
  int net_model [0:(1<<NETSIZE)-1];

  kinpira_core UUT (
    .clk       (clk),
    .xrst      (xrst),
    .reg_we    (reg_we),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_rdata (reg_rdata),
    .net_we    (net_we),
    .net_addr  (net_addr),
    .net_wdata (net_wdata),
    .img_we    (img_we),
    .img_addr  (img_addr),
    .img_wdata (img_wdata),
    .img_rdata (img_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  // Layer time and host traffic both grow with this sum
  initial begin : watchdog
    int layer_work;
    int limit;
    layer_work = 0;
    for (int k = 0; k < NCASES; k++) begin
      layer_work += (case_tab[k][C_TIN] + 2) * case_tab[k][C_TOUT];
    end
    limit = 50 * layer_work + 5000;
    repeat (limit) @(posedge clk);
    $display("Timeout: the run did not finish within %0d clock cycles", limit);
    $display("SIMULATION FAILED");
    $fatal(1, "watchdog expired");
  end

  task automatic check_value(input string name, input logic signed [63:0] actual,
                             input logic signed [63:0] expected);
    if (actual !== expected) begin
      $display("** Error at %0t: %s = %0d, expected %0d", $time, name, actual, expected);
      $display("SIMULATION FAILED");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  function automatic int rand_span(input int lo, input int span);
    return lo + int'($urandom % span);
  endfunction

  // ==============================
  // Host port access
  // ==============================
  task automatic reg_write(input logic [REGSIZE-1:0] addr, input logic [BWIDTH-1:0] data);
    @(posedge clk);
    #DRV;
    reg_we    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(posedge clk);
    #DRV;
    reg_we = 1'b0;
  endtask

  task automatic reg_expect(input logic [REGSIZE-1:0] addr, input logic [BWIDTH-1:0] expected);
    @(posedge clk);
    #DRV;
    reg_addr = addr;
    @(negedge clk);
    check_value($sformatf("reg_rdata[%0d]", addr), reg_rdata, expected);
  endtask

  task automatic img_write(input int addr, input int data);
    @(posedge clk);
    #DRV;
    img_we    = 1'b1;
    img_addr  = IMGSIZE'(addr);
    img_wdata = DWIDTH'(data);
    @(posedge clk);
    #DRV;
    img_we = 1'b0;
  endtask

  // Registered read with data valid one cycle after the address
  task automatic img_expect(input int addr, input int expected);
    @(posedge clk);
    #DRV;
    img_addr = IMGSIZE'(addr);
    @(posedge clk);
    @(negedge clk);
    check_value($sformatf("img_rdata[%0d]", addr), img_rdata, expected);
  endtask

  task automatic net_write(input int addr, input int data);
    @(posedge clk);
    #DRV;
    net_we    = 1'b1;
    net_addr  = NETSIZE'(addr);
    net_wdata = DWIDTH'(data);
    @(posedge clk);
    #DRV;
    net_we = 1'b0;
  endtask

  // ==============================
  // Reference model
  // ==============================
  // Bias scaled up, products summed at full precision, then scaled down
  function automatic longint ref_sum(input int k, input int o);
    longint acc;
    int     tin;
    int     wb;
    tin = case_tab[k][C_TIN];
    wb  = case_tab[k][C_NET] + o * (tin + 1);
    acc = longint'(net_model[wb + tin]) <<< FRACBITS;
    for (int i = 0; i < tin; i++) begin
      acc += longint'(img_model[case_tab[k][C_IN] + i]) * longint'(net_model[wb + i]);
    end
    return acc >>> FRACBITS;
  endfunction

  function automatic int relu_sat(input longint r);
    if (r < 0) begin
      return 0;
    end else if (r > MAXVAL) begin
      return MAXVAL;
    end
    return int'(r);
  endfunction

  task automatic load_layer(input int k);
    int tin;
    int in_off;
    int amp;
    int v;
    int wb;
    tin    = case_tab[k][C_TIN];
    in_off = case_tab[k][C_IN];
    amp    = case_tab[k][C_AMP];
    for (int i = 0; i < tin; i++) begin
      if (case_tab[k][C_MODE] == 0) begin
        v = rand_span(-amp, 2 * amp);
      end else begin
        v = rand_span(amp / 2, amp / 2);
      end
      img_model[in_off + i] = v;
      img_known[in_off + i] = 1'b1;
      img_write(in_off + i, v);
    end
    for (int i = 0; i < tin; i++) begin
      img_expect(in_off + i, img_model[in_off + i]);
    end
    for (int o = 0; o < case_tab[k][C_TOUT]; o++) begin
      wb = case_tab[k][C_NET] + o * (tin + 1);
      for (int i = 0; i < tin; i++) begin
        if (case_tab[k][C_MODE] == 0) begin
          v = rand_span(-amp, 2 * amp);
        end else begin
          v = rand_span(amp / 2, amp / 2);
          // Odd outputs go strongly negative
          if (o % 2 == 1) begin
            v = -v;
          end
        end
        net_model[wb + i] = v;
        net_write(wb + i, v);
      end
      v = rand_span(-amp, 2 * amp);
      net_model[wb + tin] = v;
      net_write(wb + tin, v);
    end
  endtask

  task automatic run_layer(input int k);
    logic [BWIDTH-1:0] status;
    longint            raw;
    int                expected;
    int                out_off;
    out_off = case_tab[k][C_OUT];
    reg_write(REG_IN_OFFSET, BWIDTH'(case_tab[k][C_IN]));
    reg_write(REG_OUT_OFFSET, BWIDTH'(out_off));
    reg_write(REG_NET_OFFSET, BWIDTH'(case_tab[k][C_NET]));
    reg_write(REG_BASE_PARAM, (BWIDTH'(case_tab[k][C_TOUT]) << LWIDTH)
                              | BWIDTH'(case_tab[k][C_TIN]));
    reg_write(REG_REQ, 32'd1);
    // Edge detect cycle, then busy rises on the start pulse
    reg_addr = REG_STATUS;
    @(posedge clk);
    @(negedge clk);
    check_value("ack one cycle after req", reg_rdata, 32'd1);
    @(posedge clk);
    @(negedge clk);
    check_value("ack two cycles after req", reg_rdata, 32'd0);
    // Host write while the engine owns the buffer
    @(posedge clk);
    #DRV;
    img_we    = 1'b1;
    img_addr  = IMGSIZE'(SCRATCH);
    img_wdata = DWIDTH'(img_model[SCRATCH] + 1);
    @(posedge clk);
    #DRV;
    img_we = 1'b0;
    status = '0;
    while (!status[0]) begin
      @(negedge clk);
      status = reg_rdata;
    end
    reg_write(REG_REQ, 32'd0);
    for (int o = 0; o < case_tab[k][C_TOUT]; o++) begin
      raw      = ref_sum(k, o);
      expected = relu_sat(raw);
      img_model[out_off + o] = expected;
      img_known[out_off + o] = 1'b1;
      img_expect(out_off + o, expected);
    end
  endtask

  // ==============================
  // Main sequence
  // ==============================
  initial begin : main
    int unsigned seed_init;
    seed_init = $urandom(SEED);
    xrst      = 1'b0;
    reg_we    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    net_we    = 1'b0;
    net_addr  = '0;
    net_wdata = '0;
    img_we    = 1'b0;
    img_addr  = '0;
    img_wdata = '0;
    for (int a = 0; a < (1 << IMGSIZE); a++) begin
      img_known[a] = 1'b0;
    end
    repeat (3) @(posedge clk);
    #DRV;
    xrst = 1'b1;

    // Reset values
    reg_expect(REG_STATUS, 32'd1);
    reg_expect(REG_REQ, 32'd0);
    reg_expect(REG_IN_OFFSET, 32'd0);
    reg_expect(REG_OUT_OFFSET, 32'd0);
    reg_expect(REG_NET_OFFSET, 32'd0);
    reg_expect(REG_BASE_PARAM, 32'd0);

    // Readback with the req bit kept low
    reg_write(REG_REQ, 32'hA5A5_5A5A);
    reg_expect(REG_REQ, 32'hA5A5_5A5A);
    reg_write(REG_IN_OFFSET, 32'h0000_03FF);
    reg_expect(REG_IN_OFFSET, 32'h0000_03FF);
    reg_write(REG_OUT_OFFSET, 32'h1234_5678);
    reg_expect(REG_OUT_OFFSET, 32'h1234_5678);
    reg_write(REG_NET_OFFSET, 32'hFFFF_07FF);
    reg_expect(REG_NET_OFFSET, 32'hFFFF_07FF);
    reg_write(REG_BASE_PARAM, 32'h0001_0002);
    reg_expect(REG_BASE_PARAM, 32'h0001_0002);
    reg_write(REG_STATUS, 32'hFFFF_FFFE);
    reg_expect(REG_STATUS, 32'd1);
    reg_write(5'd0, 32'hDEAD_BEEF);
    reg_expect(5'd0, 32'd0);
    reg_write(5'd5, 32'hDEAD_BEEF);
    reg_expect(5'd5, 32'd0);
    reg_write(5'd31, 32'hDEAD_BEEF);
    reg_expect(5'd31, 32'd0);
    reg_write(REG_REQ, 32'd0);
    reg_write(REG_BASE_PARAM, 32'd0);

    // Host image port
    for (int i = 0; i < 4; i++) begin
      img_model[SCRATCH + i] = rand_span(-MAXVAL, 2 * MAXVAL);
      img_known[SCRATCH + i] = 1'b1;
      img_write(SCRATCH + i, img_model[SCRATCH + i]);
      img_expect(SCRATCH + i, img_model[SCRATCH + i]);
    end

    for (int k = 0; k < NCASES; k++) begin
      load_layer(k);
      run_layer(k);
    end

    // Inputs, earlier outputs and the guarded word stay intact
    for (int a = 0; a < (1 << IMGSIZE); a++) begin
      if (img_known[a]) begin
        img_expect(a, img_model[a]);
      end
    end

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

/* kinpira.f */
logic/kinpira_pkg.sv
logic/ninjin_regs.sv
logic/ninjin_img_buf.sv
logic/gobou_dense.sv
logic/kinpira_core.sv
bench/kinpira_core_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the kinpira testbench with Verilator.
# The exit status is the simulator's: 0 on pass, nonzero on any $fatal.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module kinpira_core_tb \
  -Mdir obj_dir -o kinpira_sim \
  -f kinpira.f
status=$?
if [ $status -ne 0 ]; then
  echo "run.sh: Verilator build failed with status $status"
  exit $status
fi

./obj_dir/kinpira_sim
status=$?
if [ $status -ne 0 ]; then
  echo "run.sh: simulation failed with status $status"
  exit $status
fi

exit 0
